/* common/carpici_consts.svh */
`ifndef CARPICI_CONSTS_SVH
`define CARPICI_CONSTS_SVH

// Operand and product widths of the multiplier.
`define CARPICI_VERI_W            32
`define CARPICI_SONUC_W           64

// AXI4-Lite address width, enough for five word registers.
`define CARPICI_ADRES_W           5

// Byte offsets of the registers.
`define CARPICI_ADR_ISLEC0        5'h00
`define CARPICI_ADR_ISLEC1        5'h04
`define CARPICI_ADR_DURUM         5'h08 // Bit 0 is the ready flag.
`define CARPICI_ADR_SONUC_DUSUK   5'h0C
`define CARPICI_ADR_SONUC_YUKSEK  5'h10

`endif

/* common/carpici_pkg.sv */
`default_nettype none

package carpici_pkg;

    // The two 32-bit halves of a product, upper half first.
    typedef struct packed {
        logic [31:0] yuksek;
        logic [31:0] dusuk;
    } carpim_yarim_t;

    // One product word, seen either as a signed value or as two bus words.
    typedef union packed {
        logic signed [63:0] tam;
        carpim_yarim_t      yarim;
    } carpim_t;

    // Register index, which is the byte offset divided by four.
    typedef enum logic [2:0] {
        ISLEC0       = 3'd0,
        ISLEC1       = 3'd1,
        DURUM        = 3'd2,
        SONUC_DUSUK  = 3'd3,
        SONUC_YUKSEK = 3'd4
    } yazmac_e;

endpackage

`default_nettype wire

/* carpici/toplayici.sv */
`timescale 1ns/100ps
`default_nettype none

`include "carpici_consts.svh"

module toplayici (
    input  wire [`CARPICI_VERI_W-1:0] islec0_i,
    input  wire [`CARPICI_VERI_W-1:0] islec1_i,
    input  wire                       carry_i,
    output wire [`CARPICI_VERI_W-1:0] toplam_o,
    output wire                       carry_o
);

    // Up sweep takes log2 of the width stages, the down sweep one less.
    localparam int yukari_asama = $clog2(`CARPICI_VERI_W);
    localparam int asama_sayisi = 2 * yukari_asama - 1;

    // Distance to the partner bit in a given stage.
    function automatic int uzaklik(input int asama);
        if (asama <= yukari_asama)
            return 1 << (asama - 1);
        return 1 << (asama_sayisi - asama);
    endfunction

    // True where a stage holds a prefix cell rather than a plain wire.
    function automatic bit hucre_var(input int asama, input int bit_no);
        int seviye;
        if (asama <= yukari_asama)
            return ((bit_no + 1) % (1 << asama)) == 0;
        seviye = asama_sayisi - asama;
        return (((bit_no + 1) % (1 << (seviye + 1))) == (1 << seviye)) &&
               (bit_no >= (1 << (seviye + 1)));
    endfunction

    wire [`CARPICI_VERI_W-1:0] g [0:asama_sayisi];
    wire [`CARPICI_VERI_W-1:0] p [0:asama_sayisi];
    wire [`CARPICI_VERI_W-1:0] tasima;

    // The carry in is folded into the generate of bit 0.
    assign p[0] = islec0_i ^ islec1_i;
    assign g[0] = (islec0_i & islec1_i) |
                  {{(`CARPICI_VERI_W-1){1'b0}}, p[0][0] & carry_i};

    for (genvar s = 1; s <= asama_sayisi; s++) begin : g_asama
        for (genvar i = 0; i < `CARPICI_VERI_W; i++) begin : g_bit
            if (hucre_var(s, i)) begin : g_hucre
                assign g[s][i] = g[s-1][i] | (p[s-1][i] & g[s-1][i - uzaklik(s)]);
                assign p[s][i] = p[s-1][i] & p[s-1][i - uzaklik(s)];
            end else begin : g_gecis
                assign g[s][i] = g[s-1][i];
                assign p[s][i] = p[s-1][i];
            end
        end
    end

    // After the last stage every g bit is the carry out of bits i down to 0.
    assign tasima   = {g[asama_sayisi][`CARPICI_VERI_W-2:0], carry_i};
    assign toplam_o = p[0] ^ tasima;
    assign carry_o  = g[asama_sayisi][`CARPICI_VERI_W-1];

endmodule

`default_nettype wire

/* carpici/carpici.sv */
`timescale 1ns/100ps
`default_nettype none

`include "carpici_consts.svh"

module carpici (
    input  wire                          clk_i,
    input  wire [`CARPICI_VERI_W-1:0]    islec0_i,
    input  wire [`CARPICI_VERI_W-1:0]    islec1_i,
    input  wire                          islem_gecerli_i,
    output carpici_pkg::carpim_t         carpim_o,
    output wire                          carpim_gecerli_o
);

    // Rows 0 to 31 are the partial products. Compressor k writes its sum
    // to row 32+2k and its carry to row 33+2k, so rows 90 and 91 are the
    // last pair.
    localparam int csa_sayisi = 30;
    localparam int satir_sayisi = 32 + 2 * csa_sayisi;

    // Input rows of each compressor, grouped by tree level.
    localparam int csa_giris [0:csa_sayisi-1][0:2] = '{
        '{ 0,  1,  2}, '{ 3,  4,  5}, '{ 6,  7,  8}, '{ 9, 10, 11}, '{12, 13, 14},
        '{15, 16, 17}, '{18, 19, 20}, '{21, 22, 23}, '{24, 25, 26}, '{27, 28, 29},
        '{32, 33, 34}, '{35, 36, 37}, '{38, 39, 40}, '{41, 42, 43}, '{44, 45, 46},
        '{47, 48, 49}, '{50, 51, 30},
        '{52, 53, 54}, '{55, 56, 57}, '{58, 59, 60}, '{61, 62, 63}, '{64, 65, 31},
        '{66, 67, 68}, '{69, 70, 71}, '{72, 73, 74},
        '{76, 77, 78}, '{79, 80, 81},
        '{82, 83, 84},
        '{86, 87, 85},
        '{88, 89, 75}
    };

    wire [`CARPICI_VERI_W-1:0]  mutlak0;
    wire [`CARPICI_VERI_W-1:0]  mutlak1;
    wire                        isaret_farkli;
    wire [`CARPICI_SONUC_W-1:0] satir [0:satir_sayisi-1];
    wire [`CARPICI_SONUC_W-1:0] mutlak_carpim;
    wire [`CARPICI_SONUC_W-1:0] sonuc;
    wire                        ara_carry;

    // Magnitudes of the operands. The most negative value maps to 2^31,
    // which is still correct read as unsigned.
    assign mutlak0 = islec0_i[`CARPICI_VERI_W-1] ? (~islec0_i + 1'b1) : islec0_i;
    assign mutlak1 = islec1_i[`CARPICI_VERI_W-1] ? (~islec1_i + 1'b1) : islec1_i;
    assign isaret_farkli = islec0_i[`CARPICI_VERI_W-1] ^ islec1_i[`CARPICI_VERI_W-1];

    for (genvar i = 0; i < `CARPICI_VERI_W; i++) begin : g_kismi
        assign satir[i] = mutlak1[i] ?
                          ({{`CARPICI_VERI_W{1'b0}}, mutlak0} << i) : '0;
    end

    // 3:2 compressors. The carry row is shifted up by one bit.
    for (genvar k = 0; k < csa_sayisi; k++) begin : g_csa
        wire [`CARPICI_SONUC_W-1:0] a;
        wire [`CARPICI_SONUC_W-1:0] b;
        wire [`CARPICI_SONUC_W-1:0] c;
        wire [`CARPICI_SONUC_W-1:0] cogunluk;

        assign a        = satir[csa_giris[k][0]];
        assign b        = satir[csa_giris[k][1]];
        assign c        = satir[csa_giris[k][2]];
        assign cogunluk = (a & b) | (a & c) | (b & c);

        assign satir[32 + 2 * k] = a ^ b ^ c;
        assign satir[33 + 2 * k] = {cogunluk[`CARPICI_SONUC_W-2:0], 1'b0};
    end

    toplayici u_toplayici_dusuk (
        .islec0_i (satir[satir_sayisi-2][`CARPICI_VERI_W-1:0]),
        .islec1_i (satir[satir_sayisi-1][`CARPICI_VERI_W-1:0]),
        .carry_i  (1'b0),
        .toplam_o (mutlak_carpim[`CARPICI_VERI_W-1:0]),
        .carry_o  (ara_carry)
    );

    // A carry out of bit 63 falls outside the product.
    toplayici u_toplayici_yuksek (
        .islec0_i (satir[satir_sayisi-2][`CARPICI_SONUC_W-1:`CARPICI_VERI_W]),
        .islec1_i (satir[satir_sayisi-1][`CARPICI_SONUC_W-1:`CARPICI_VERI_W]),
        .carry_i  (ara_carry),
        .toplam_o (mutlak_carpim[`CARPICI_SONUC_W-1:`CARPICI_VERI_W]),
        .carry_o  ()
    );

    assign sonuc = isaret_farkli ? (~mutlak_carpim + 1'b1) : mutlak_carpim;

    assign carpim_o         = sonuc;
    assign carpim_gecerli_o = islem_gecerli_i; // Same cycle, no pipeline.

endmodule

`default_nettype wire

/* rtl/axi_carpici.sv */
`timescale 1ns/100ps
`default_nettype none

`include "carpici_consts.svh"

module axi_carpici (
    input  wire                           clk_i,
    input  wire                           rst_i,
    input  wire [`CARPICI_ADRES_W-1:0]    awaddr_i,
    input  wire                           awvalid_i,
    output wire                           awready_o,
    input  wire [`CARPICI_VERI_W-1:0]     wdata_i,
    input  wire [`CARPICI_VERI_W/8-1:0]   wstrb_i,
    input  wire                           wvalid_i,
    output wire                           wready_o,
    output wire [1:0]                     bresp_o,
    output wire                           bvalid_o,
    input  wire                           bready_i,
    input  wire [`CARPICI_ADRES_W-1:0]    araddr_i,
    input  wire                           arvalid_i,
    output wire                           arready_o,
    output wire [`CARPICI_VERI_W-1:0]     rdata_o,
    output wire [1:0]                     rresp_o,
    output wire                           rvalid_o,
    input  wire                           rready_i,
    output wire [`CARPICI_VERI_W-1:0]     islec0_o,
    output wire [`CARPICI_VERI_W-1:0]     islec1_o,
    output wire                           islem_gecerli_o,
    input  wire carpici_pkg::carpim_t     carpim_i,
    input  wire                           carpim_gecerli_i
);

    import carpici_pkg::*;

    // Returns 1 for a mapped offset and gives its register index.
    function automatic logic adres_coz(input  logic [`CARPICI_ADRES_W-1:0] adres,
                                       output yazmac_e                     yazmac);
        adres_coz = 1'b1;
        yazmac    = ISLEC0;
        case (adres)
            `CARPICI_ADR_ISLEC0:       yazmac = ISLEC0;
            `CARPICI_ADR_ISLEC1:       yazmac = ISLEC1;
            `CARPICI_ADR_DURUM:        yazmac = DURUM;
            `CARPICI_ADR_SONUC_DUSUK:  yazmac = SONUC_DUSUK;
            `CARPICI_ADR_SONUC_YUKSEK: yazmac = SONUC_YUKSEK;
            default:                   adres_coz = 1'b0;
        endcase
    endfunction

    logic                       yaz_hazir;   // Drives both awready and wready.
    logic                       bvalid_q;
    logic [1:0]                 bresp_q;
    logic                       arready_q;
    logic                       rvalid_q;
    logic [1:0]                 rresp_q;
    logic [`CARPICI_VERI_W-1:0] rdata_q;
    logic [`CARPICI_VERI_W-1:0] islec0_q;
    logic [`CARPICI_VERI_W-1:0] islec1_q;
    logic                       baslat_q;
    logic                       hazir_q;
    carpim_t                    carpim_q;

    yazmac_e yaz_yazmac;
    yazmac_e oku_yazmac;
    logic    yaz_eslesti;
    logic    oku_eslesti;
    logic    yaz_hs;
    logic    oku_hs;
    logic    tam_kelime;

    always_comb begin
        yaz_eslesti = adres_coz(awaddr_i, yaz_yazmac);
        oku_eslesti = adres_coz(araddr_i, oku_yazmac);
    end

    assign yaz_hs     = yaz_hazir && awvalid_i && wvalid_i;
    assign oku_hs     = arready_q && arvalid_i;
    assign tam_kelime = &wstrb_i;

    // Write channel, one outstanding response at a time.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            yaz_hazir <= 1'b0;
            bvalid_q  <= 1'b0;
        end else begin
            yaz_hazir <= awvalid_i && wvalid_i && !yaz_hazir && !bvalid_q;
            if (yaz_hs) begin
                bvalid_q <= 1'b1;
            end else if (bready_i) begin
                bvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (yaz_hs) begin
            bresp_q <= yaz_eslesti ? 2'b00 : 2'b10; // OKAY or SLVERR.
        end
    end

    // Operands, start pulse and product capture.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            islec0_q <= '0;
            islec1_q <= '0;
            baslat_q <= 1'b0;
            hazir_q  <= 1'b0;
            carpim_q <= '0;
        end else begin
            baslat_q <= 1'b0;
            if (carpim_gecerli_i) begin
                carpim_q.tam <= carpim_i.tam;
                hazir_q      <= 1'b1;
            end
            if (yaz_hs && yaz_eslesti && tam_kelime) begin
                case (yaz_yazmac)
                    ISLEC0: begin
                        islec0_q <= wdata_i;
                        hazir_q  <= 1'b0;
                    end
                    ISLEC1: begin
                        islec1_q <= wdata_i;
                        hazir_q  <= 1'b0;
                        baslat_q <= 1'b1; // Multiply runs in the next cycle.
                    end
                    default: ;
                endcase
            end
        end
    end

    // Read channel. Address is taken again once the response has gone.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            arready_q <= 1'b0;
            rvalid_q  <= 1'b0;
        end else begin
            if (oku_hs) begin
                arready_q <= 1'b0;
            end else if (!rvalid_q || rready_i) begin
                arready_q <= 1'b1;
            end
            if (oku_hs) begin
                rvalid_q <= 1'b1;
            end else if (rready_i) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (oku_hs) begin
            rresp_q <= oku_eslesti ? 2'b00 : 2'b10;
            rdata_q <= '0;
            if (oku_eslesti) begin
                case (oku_yazmac)
                    ISLEC0:       rdata_q <= islec0_q;
                    ISLEC1:       rdata_q <= islec1_q;
                    DURUM:        rdata_q <= {{(`CARPICI_VERI_W-1){1'b0}}, hazir_q};
                    SONUC_DUSUK:  rdata_q <= carpim_q.yarim.dusuk;
                    SONUC_YUKSEK: rdata_q <= carpim_q.yarim.yuksek;
                    default:      rdata_q <= '0;
                endcase
            end
        end
    end

    assign awready_o       = yaz_hazir;
    assign wready_o        = yaz_hazir;
    assign bvalid_o        = bvalid_q;
    assign bresp_o         = bresp_q;
    assign arready_o       = arready_q;
    assign rvalid_o        = rvalid_q;
    assign rresp_o         = rresp_q;
    assign rdata_o         = rdata_q;
    assign islec0_o        = islec0_q;
    assign islec1_o        = islec1_q;
    assign islem_gecerli_o = baslat_q;

endmodule

`default_nettype wire

/* rtl/carpici_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "carpici_consts.svh"

module carpici_top (
    input  wire                           clk_i,
    input  wire                           rst_i,
    input  wire [`CARPICI_ADRES_W-1:0]    awaddr_i,
    input  wire                           awvalid_i,
    output wire                           awready_o,
    input  wire [`CARPICI_VERI_W-1:0]     wdata_i,
    input  wire [`CARPICI_VERI_W/8-1:0]   wstrb_i,
    input  wire                           wvalid_i,
    output wire                           wready_o,
    output wire [1:0]                     bresp_o,
    output wire                           bvalid_o,
    input  wire                           bready_i,
    input  wire [`CARPICI_ADRES_W-1:0]    araddr_i,
    input  wire                           arvalid_i,
    output wire                           arready_o,
    output wire [`CARPICI_VERI_W-1:0]     rdata_o,
    output wire [1:0]                     rresp_o,
    output wire                           rvalid_o,
    input  wire                           rready_i
);

    import carpici_pkg::*;

    wire [`CARPICI_VERI_W-1:0] islec0;
    wire [`CARPICI_VERI_W-1:0] islec1;
    wire                       islem_gecerli;
    carpim_t                   carpim;
    wire                       carpim_gecerli;

    axi_carpici u_axi_carpici (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .awaddr_i         (awaddr_i),
        .awvalid_i        (awvalid_i),
        .awready_o        (awready_o),
        .wdata_i          (wdata_i),
        .wstrb_i          (wstrb_i),
        .wvalid_i         (wvalid_i),
        .wready_o         (wready_o),
        .bresp_o          (bresp_o),
        .bvalid_o         (bvalid_o),
        .bready_i         (bready_i),
        .araddr_i         (araddr_i),
        .arvalid_i        (arvalid_i),
        .arready_o        (arready_o),
        .rdata_o          (rdata_o),
        .rresp_o          (rresp_o),
        .rvalid_o         (rvalid_o),
        .rready_i         (rready_i),
        .islec0_o         (islec0),
        .islec1_o         (islec1),
        .islem_gecerli_o  (islem_gecerli),
        .carpim_i         (carpim),
        .carpim_gecerli_i (carpim_gecerli)
    );

    carpici u_carpici (
        .clk_i            (clk_i),
        .islec0_i         (islec0),
        .islec1_i         (islec1),
        .islem_gecerli_i  (islem_gecerli),
        .carpim_o         (carpim),
        .carpim_gecerli_o (carpim_gecerli)
    );

endmodule

`default_nettype wire

/* test/axi_surucu.svh */
`ifndef AXI_SURUCU_SVH
`define AXI_SURUCU_SVH

// One AXI4-Lite write. The response waits bekleme cycles before bready rises.
task automatic veri_yaz(input  logic [`CARPICI_ADRES_W-1:0] adres,
                        input  logic [`CARPICI_VERI_W-1:0]  veri,
                        input  logic [3:0]                  strb,
                        input  int                          bekleme,
                        output logic [1:0]                  yanit);
    @(posedge clk);
    awaddr  <= adres;
    wdata   <= veri;
    wstrb   <= strb;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    bready  <= 1'b0;
    do @(negedge clk); while (!awready); // Handshake on the next rising edge.
    kontrol_et("wready with awready", wready, 1'b1);
    @(posedge clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    repeat (bekleme) @(posedge clk);
    bready <= 1'b1;
    do @(negedge clk); while (!bvalid);
    yanit = bresp;
    @(posedge clk);
    bready <= 1'b0;
    @(negedge clk);
    kontrol_et("bvalid after response", bvalid, 0);
endtask

// One AXI4-Lite read, with rready held low for bekleme cycles.
task automatic adresten_oku(input  logic [`CARPICI_ADRES_W-1:0] adres,
                            input  int                          bekleme,
                            output logic [`CARPICI_VERI_W-1:0]  veri,
                            output logic [1:0]                  yanit);
    @(posedge clk);
    araddr  <= adres;
    arvalid <= 1'b1;
    rready  <= 1'b0;
    do @(negedge clk); while (!arready);
    @(posedge clk);
    arvalid <= 1'b0;
    repeat (bekleme) @(posedge clk);
    rready <= 1'b1;
    do @(negedge clk); while (!rvalid);
    veri  = rdata;
    yanit = rresp;
    @(posedge clk);
    rready <= 1'b0;
    @(negedge clk);
    kontrol_et("rvalid after response", rvalid, 0);
endtask

`endif

/* test/tb_carpici.sv */
`timescale 1ns/100ps
`default_nettype none

`include "carpici_consts.svh"

module tb_carpici;

    // 200 multiplies of at most 40 cycles each, plus room for reset and the rest.
    localparam int zaman_asimi = 200 * 40 + 500;

    logic                           clk = 1'b0;
    logic                           rst;
    logic [`CARPICI_ADRES_W-1:0]    awaddr;
    logic                           awvalid;
    wire                            awready;
    logic [`CARPICI_VERI_W-1:0]     wdata;
    logic [`CARPICI_VERI_W/8-1:0]   wstrb;
    logic                           wvalid;
    wire                            wready;
    wire  [1:0]                     bresp;
    wire                            bvalid;
    logic                           bready;
    logic [`CARPICI_ADRES_W-1:0]    araddr;
    logic                           arvalid;
    wire                            arready;
    wire  [`CARPICI_VERI_W-1:0]     rdata;
    wire  [1:0]                     rresp;
    wire                            rvalid;
    logic                           rready;

    integer tohum;
    int     sayac = 0;

    carpici_top uut (
        .clk_i     (clk),
        .rst_i     (rst),
        .awaddr_i  (awaddr),
        .awvalid_i (awvalid),
        .awready_o (awready),
        .wdata_i   (wdata),
        .wstrb_i   (wstrb),
        .wvalid_i  (wvalid),
        .wready_o  (wready),
        .bresp_o   (bresp),
        .bvalid_o  (bvalid),
        .bready_i  (bready),
        .araddr_i  (araddr),
        .arvalid_i (arvalid),
        .arready_o (arready),
        .rdata_o   (rdata),
        .rresp_o   (rresp),
        .rvalid_o  (rvalid),
        .rready_i  (rready)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        sayac <= sayac + 1;
        if (sayac == zaman_asimi) begin
            $display("Timeout: the run did not finish within %0d cycles.", zaman_asimi);
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
    end

    task automatic kontrol_et(input string ad, input logic [63:0] gozlenen,
                              input logic [63:0] beklenen);
        if (gozlenen !== beklenen) begin
            $display("mismatch %s: observed 0x%h expected 0x%h", ad, gozlenen, beklenen);
            $display("SOME TESTS FAILED");
            $fatal(1, "Stopped at the first error.");
        end
    endtask

    `include "axi_surucu.svh"

    // Signed 64-bit product of the two operands.
    function automatic logic [63:0] carpim_modeli(input logic [31:0] a, input logic [31:0] b);
        longint sa;
        longint sb;
        sa = $signed(a);
        sb = $signed(b);
        return sa * sb;
    endfunction

    function automatic int bekleme_sec();
        return $unsigned($random(tohum)) % 4;
    endfunction

    // Writes both operands, polls the ready flag and checks both product words.
    task automatic carpma_dene(input logic [31:0] a, input logic [31:0] b);
        logic [63:0] beklenen;
        logic [31:0] veri;
        logic [1:0]  yanit;
        beklenen = carpim_modeli(a, b);
        veri_yaz(`CARPICI_ADR_ISLEC0, a, 4'hF, bekleme_sec(), yanit);
        kontrol_et("bresp islec0", yanit, 2'b00);
        veri_yaz(`CARPICI_ADR_ISLEC1, b, 4'hF, bekleme_sec(), yanit);
        kontrol_et("bresp islec1", yanit, 2'b00);
        veri = '0;
        while (veri != 32'd1) begin
            adresten_oku(`CARPICI_ADR_DURUM, bekleme_sec(), veri, yanit);
            kontrol_et("rresp durum", yanit, 2'b00);
        end
        adresten_oku(`CARPICI_ADR_SONUC_DUSUK, bekleme_sec(), veri, yanit);
        kontrol_et("sonuc_dusuk", veri, beklenen[31:0]);
        adresten_oku(`CARPICI_ADR_SONUC_YUKSEK, bekleme_sec(), veri, yanit);
        kontrol_et("sonuc_yuksek", veri, beklenen[63:32]);
    endtask

    logic [31:0] kose0 [0:4] = '{32'h8000_0000, 32'h8000_0000, 32'h1234_5678,
                                 32'hFFFF_FFFF, 32'h7FFF_FFFF};
    logic [31:0] kose1 [0:4] = '{32'h8000_0000, 32'hFFFF_FFFF, 32'h0000_0000,
                                 32'hFFFF_FFFF, 32'h8000_0000};

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [63:0] son_carpim;
        logic [31:0] veri;
        logic [1:0]  yanit;

        tohum   = 32'h383f;
        rst     = 1'b1;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        adresten_oku(`CARPICI_ADR_DURUM, 0, veri, yanit);
        kontrol_et("durum after reset", veri, 32'd0);
        adresten_oku(`CARPICI_ADR_SONUC_DUSUK, 0, veri, yanit);
        kontrol_et("sonuc_dusuk after reset", veri, 32'd0);

        for (int i = 0; i < 200; i++) begin
            if (i < 5) begin
                a = kose0[i];
                b = kose1[i];
            end else begin
                a = $random(tohum);
                b = $random(tohum);
            end
            carpma_dene(a, b);
        end

        // A new first operand clears the ready flag.
        a = $random(tohum);
        b = $random(tohum);
        veri_yaz(`CARPICI_ADR_ISLEC0, a, 4'hF, bekleme_sec(), yanit);
        adresten_oku(`CARPICI_ADR_DURUM, bekleme_sec(), veri, yanit);
        kontrol_et("durum after islec0 write", veri, 32'd0);
        carpma_dene(a, b);
        son_carpim = carpim_modeli(a, b);

        adresten_oku(5'h14, bekleme_sec(), veri, yanit);
        kontrol_et("rresp unmapped", yanit, 2'b10);
        veri_yaz(5'h14, 32'h0bad_0bad, 4'hF, bekleme_sec(), yanit);
        kontrol_et("bresp unmapped", yanit, 2'b10);

        veri_yaz(`CARPICI_ADR_SONUC_DUSUK, 32'hDEAD_BEEF, 4'hF, bekleme_sec(), yanit);
        kontrol_et("bresp sonuc_dusuk", yanit, 2'b00);
        adresten_oku(`CARPICI_ADR_SONUC_DUSUK, bekleme_sec(), veri, yanit);
        kontrol_et("sonuc_dusuk after write", veri, son_carpim[31:0]);
        adresten_oku(`CARPICI_ADR_SONUC_YUKSEK, bekleme_sec(), veri, yanit);
        kontrol_et("sonuc_yuksek after write", veri, son_carpim[63:32]);

        // A partial strobe leaves the operand and the flag alone.
        veri_yaz(`CARPICI_ADR_ISLEC0, ~a, 4'b0011, bekleme_sec(), yanit);
        kontrol_et("bresp partial strobe", yanit, 2'b00);
        adresten_oku(`CARPICI_ADR_ISLEC0, bekleme_sec(), veri, yanit);
        kontrol_et("islec0 after partial strobe", veri, a);
        adresten_oku(`CARPICI_ADR_DURUM, bekleme_sec(), veri, yanit);
        kontrol_et("durum after partial strobe", veri, 32'd1);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+common
+incdir+test
common/carpici_pkg.sv
carpici/toplayici.sv
carpici/carpici.sv
rtl/axi_carpici.sv
rtl/carpici_top.sv
test/tb_carpici.sv
